/* cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

////////////////////////////////////////
// Datapath sizes
////////////////////////////////////////

// One machine word, also the instruction width
`define REG_W 16

////////////////////////////////////////
// Register file sizes
////////////////////////////////////////

`define REG_CNT 8  // General purpose R0..R7
`define REG_AW 3   // Enough to index REG_CNT

`endif

/* cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	////////////////////////////////////////
	// ALU operations
	////////////////////////////////////////

	typedef enum logic [2:0] {
		ALU_ADD  = 3'd0,
		ALU_SUB  = 3'd1,
		ALU_AND  = 3'd2,
		ALU_OR   = 3'd3,
		ALU_SLL  = 3'd4,
		ALU_SRL  = 3'd5,
		ALU_SRA  = 3'd6,
		ALU_PASS = 3'd7  // Result is op1
	} alu_op_t;

	////////////////////////////////////////
	// Major opcodes, instr[15:11]
	////////////////////////////////////////

	localparam logic [4:0] OPC_ADDIU  = 5'b01001;
	localparam logic [4:0] OPC_ADDIU3 = 5'b01000;
	localparam logic [4:0] OPC_LI     = 5'b01101;
	localparam logic [4:0] OPC_RRR    = 5'b11100;  // ADDU, SUBU
	localparam logic [4:0] OPC_LOGIC  = 5'b11101;  // AND, OR
	localparam logic [4:0] OPC_SHIFT  = 5'b00110;  // SLL, SRL, SRA
	localparam logic [4:0] OPC_MOVE   = 5'b01111;
	localparam logic [4:0] OPC_SW     = 5'b11011;
	localparam logic [4:0] OPC_NOP    = 5'b00001;

	// Sub-function fields
	localparam logic [1:0] FN_ADDU = 2'b01;  // instr[1:0]
	localparam logic [1:0] FN_SUBU = 2'b11;
	localparam logic [4:0] FN_AND  = 5'b01100;  // instr[4:0]
	localparam logic [4:0] FN_OR   = 5'b01101;
	localparam logic [1:0] FN_SLL  = 2'b00;  // instr[1:0]
	localparam logic [1:0] FN_SRL  = 2'b10;
	localparam logic [1:0] FN_SRA  = 2'b11;

endpackage

`default_nettype wire

/* reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module reg_file (
	input  logic                clk,
	input  logic                rst_n,
	input  logic [`REG_AW-1:0]  rd_addr1,
	input  logic [`REG_AW-1:0]  rd_addr2,
	input  logic                wr_en,
	input  logic [`REG_AW-1:0]  wr_addr,
	input  logic [`REG_W-1:0]   wr_data,
	output logic [`REG_W-1:0]   rd_data1,
	output logic [`REG_W-1:0]   rd_data2
);

	logic [`REG_W-1:0] regs [`REG_CNT];

	////////////////////////////////////////
	// Write port
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `REG_CNT; i++) begin
				regs[i] <= '0;  // Architectural state starts at zero
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	////////////////////////////////////////
	// Read ports with write-through
	////////////////////////////////////////

	// A write landing this edge is already visible to the reader
	assign rd_data1 = (wr_en && wr_addr == rd_addr1) ? wr_data : regs[rd_addr1];
	assign rd_data2 = (wr_en && wr_addr == rd_addr2) ? wr_data : regs[rd_addr2];

endmodule

`default_nettype wire

/* id_exe.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module id_exe (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                hold,
	input  logic [`REG_W-1:0]   instr,
	input  logic                instr_valid,
	output logic                instr_ready,
	output logic [`REG_AW-1:0]  rd_addr1,
	output logic [`REG_AW-1:0]  rd_addr2,
	input  logic [`REG_W-1:0]   rd_data1,
	input  logic [`REG_W-1:0]   rd_data2,
	input  logic                fwd_en,
	input  logic [`REG_AW-1:0]  fwd_addr,
	input  logic [`REG_W-1:0]   fwd_data,
	output logic [`REG_W-1:0]   op1,
	output logic [`REG_W-1:0]   op2,
	output cpu_pkg::alu_op_t    alu_op,
	output logic                reg_write,
	output logic [`REG_AW-1:0]  dst_addr,
	output logic                mem_write_req,
	output logic [`REG_W-1:0]   mem_write_value
);
	import cpu_pkg::*;

	logic [4:0]         opcode;
	logic [`REG_AW-1:0] rx, ry, rz;
	logic [`REG_W-1:0]  src1, src2;
	logic [`REG_W-1:0]  shamt;
	logic               accept;

	logic [`REG_W-1:0]  d_op1, d_op2;
	alu_op_t            d_alu_op;
	logic               d_reg_write;
	logic               d_mem_write;
	logic [`REG_AW-1:0] d_dst;

	assign opcode = instr[15:11];
	assign rx     = instr[10:8];
	assign ry     = instr[7:5];
	assign rz     = instr[4:2];

	assign instr_ready = !hold;
	assign accept      = instr_valid && instr_ready;

	assign rd_addr1 = rx;
	assign rd_addr2 = ry;

	// Result of the instruction now in exe_alu wins over the register file
	assign src1 = (fwd_en && fwd_addr == rx) ? fwd_data : rd_data1;
	assign src2 = (fwd_en && fwd_addr == ry) ? fwd_data : rd_data2;

	assign shamt = (instr[4:2] == 3'd0) ? `REG_W'd8 : {{(`REG_W-3){1'b0}}, instr[4:2]};

	////////////////////////////////////////
	// Decode
	////////////////////////////////////////

	always_comb begin
		d_op1       = '0;
		d_op2       = '0;
		d_alu_op    = ALU_PASS;
		d_reg_write = 1'b0;
		d_mem_write = 1'b0;
		d_dst       = rx;  // Most formats write rx
		case (opcode)
			OPC_ADDIU: begin
				d_op1       = src1;
				d_op2       = {{8{instr[7]}}, instr[7:0]};
				d_alu_op    = ALU_ADD;
				d_reg_write = 1'b1;
			end
			OPC_ADDIU3: begin
				d_op1       = src1;
				d_op2       = {{12{instr[3]}}, instr[3:0]};
				d_alu_op    = ALU_ADD;
				d_reg_write = 1'b1;
				d_dst       = ry;
			end
			OPC_LI: begin
				d_op1       = {8'b0, instr[7:0]};  // Zero extended
				d_reg_write = 1'b1;
			end
			OPC_RRR: begin
				d_op1    = src1;
				d_op2    = src2;
				d_dst    = rz;
				d_alu_op = (instr[1:0] == FN_SUBU) ? ALU_SUB : ALU_ADD;
				d_reg_write = (instr[1:0] == FN_ADDU) || (instr[1:0] == FN_SUBU);
			end
			OPC_LOGIC: begin
				d_op1    = src1;
				d_op2    = src2;
				d_alu_op = (instr[4:0] == FN_OR) ? ALU_OR : ALU_AND;
				d_reg_write = (instr[4:0] == FN_AND) || (instr[4:0] == FN_OR);
			end
			OPC_SHIFT: begin
				d_op1 = src2;  // Shifts operate on ry
				d_op2 = shamt;
				case (instr[1:0])
					FN_SLL: d_alu_op = ALU_SLL;
					FN_SRL: d_alu_op = ALU_SRL;
					FN_SRA: d_alu_op = ALU_SRA;
					default: d_alu_op = ALU_PASS;
				endcase
				d_reg_write = (instr[1:0] != 2'b01);
			end
			OPC_MOVE: begin
				d_op1       = src2;
				d_reg_write = (instr[4:0] == 5'b00000);
			end
			OPC_SW: begin
				d_op1       = src1;  // Base rx
				d_op2       = {{11{instr[4]}}, instr[4:0]};
				d_alu_op    = ALU_ADD;
				d_mem_write = 1'b1;
			end
			OPC_NOP: d_alu_op = ALU_PASS;
			default: d_alu_op = ALU_PASS;  // Unsupported encodings run as NOP
		endcase
	end

	////////////////////////////////////////
	// Stage registers
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			alu_op        <= ALU_PASS;
			reg_write     <= 1'b0;
			mem_write_req <= 1'b0;
		end else if (accept) begin
			alu_op        <= d_alu_op;
			reg_write     <= d_reg_write;
			mem_write_req <= d_mem_write;
		end else begin
			alu_op        <= ALU_PASS;  // Bubble
			reg_write     <= 1'b0;
			mem_write_req <= 1'b0;
		end
	end

	// Payload zeroed in a bubble
	always_ff @(posedge clk) begin
		op1             <= accept ? d_op1 : '0;
		op2             <= accept ? d_op2 : '0;
		dst_addr        <= accept ? d_dst : '0;
		mem_write_value <= accept ? src2 : '0;  // Store data is ry
	end

endmodule

`default_nettype wire

/* exe_alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module exe_alu (
	input  logic                clk,
	input  logic                rst_n,
	input  logic [`REG_W-1:0]   op1,
	input  logic [`REG_W-1:0]   op2,
	input  cpu_pkg::alu_op_t    alu_op,
	input  logic                reg_write,
	input  logic [`REG_AW-1:0]  dst_addr,
	input  logic                mem_write_req,
	input  logic [`REG_W-1:0]   mem_write_value_in,
	output logic                fwd_en,
	output logic [`REG_AW-1:0]  fwd_addr,
	output logic [`REG_W-1:0]   fwd_data,
	output logic                wb_valid,
	output logic [`REG_AW-1:0]  wb_addr,
	output logic [`REG_W-1:0]   wb_data,
	output logic                mem_write,
	output logic [`REG_W-1:0]   mem_addr,
	output logic [`REG_W-1:0]   mem_write_value
);
	import cpu_pkg::*;

	logic [`REG_W-1:0] result;

	////////////////////////////////////////
	// Combinational ALU
	////////////////////////////////////////

	always_comb begin
		result = op1;
		case (alu_op)
			ALU_ADD:  result = op1 + op2;  // Also store address
			ALU_SUB:  result = op1 - op2;
			ALU_AND:  result = op1 & op2;
			ALU_OR:   result = op1 | op2;
			ALU_SLL:  result = op1 << op2[3:0];
			ALU_SRL:  result = op1 >> op2[3:0];
			ALU_SRA:  result = $signed(op1) >>> op2[3:0];
			ALU_PASS: result = op1;
			default:  result = op1;
		endcase
	end

	// Bypass back to decode for the next instruction
	assign fwd_en   = reg_write;
	assign fwd_addr = dst_addr;
	assign fwd_data = result;

	////////////////////////////////////////
	// Result registers
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_valid  <= 1'b0;
			mem_write <= 1'b0;
		end else begin
			wb_valid  <= reg_write;  // One cycle pulse per instruction
			mem_write <= mem_write_req;
		end
	end

	always_ff @(posedge clk) begin
		if (reg_write) begin
			wb_addr <= dst_addr;
			wb_data <= result;
		end
		if (mem_write_req) begin
			mem_addr        <= result;
			mem_write_value <= mem_write_value_in;
		end
	end

endmodule

`default_nettype wire

/* exe_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module exe_core (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                hold,
	input  logic [`REG_W-1:0]   instr,
	input  logic                instr_valid,
	output logic                instr_ready,
	output logic                wb_valid,
	output logic [`REG_AW-1:0]  wb_addr,
	output logic [`REG_W-1:0]   wb_data,
	output logic                mem_write,
	output logic [`REG_W-1:0]   mem_addr,
	output logic [`REG_W-1:0]   mem_write_value
);
	import cpu_pkg::*;

	logic [`REG_AW-1:0] rd_addr1, rd_addr2;
	logic [`REG_W-1:0]  rd_data1, rd_data2;
	logic               fwd_en;
	logic [`REG_AW-1:0] fwd_addr;
	logic [`REG_W-1:0]  fwd_data;
	logic [`REG_W-1:0]  op1, op2;
	alu_op_t            alu_op;
	logic               reg_write;
	logic [`REG_AW-1:0] dst_addr;
	logic               mem_write_req;
	logic [`REG_W-1:0]  store_value;  // Decoded ry for SW

	////////////////////////////////////////
	// Register file, written by exe_alu
	////////////////////////////////////////

	reg_file u_reg_file (
		.clk      (clk),
		.rst_n    (rst_n),
		.rd_addr1 (rd_addr1),
		.rd_addr2 (rd_addr2),
		.wr_en    (wb_valid),
		.wr_addr  (wb_addr),
		.wr_data  (wb_data),
		.rd_data1 (rd_data1),
		.rd_data2 (rd_data2)
	);

	id_exe u_id_exe (
		.clk             (clk),
		.rst_n           (rst_n),
		.hold            (hold),
		.instr           (instr),
		.instr_valid     (instr_valid),
		.instr_ready     (instr_ready),
		.rd_addr1        (rd_addr1),
		.rd_addr2        (rd_addr2),
		.rd_data1        (rd_data1),
		.rd_data2        (rd_data2),
		.fwd_en          (fwd_en),
		.fwd_addr        (fwd_addr),
		.fwd_data        (fwd_data),
		.op1             (op1),
		.op2             (op2),
		.alu_op          (alu_op),
		.reg_write       (reg_write),
		.dst_addr        (dst_addr),
		.mem_write_req   (mem_write_req),
		.mem_write_value (store_value)
	);

	exe_alu u_exe_alu (
		.clk                (clk),
		.rst_n              (rst_n),
		.op1                (op1),
		.op2                (op2),
		.alu_op             (alu_op),
		.reg_write          (reg_write),
		.dst_addr           (dst_addr),
		.mem_write_req      (mem_write_req),
		.mem_write_value_in (store_value),
		.fwd_en             (fwd_en),
		.fwd_addr           (fwd_addr),
		.fwd_data           (fwd_data),
		.wb_valid           (wb_valid),
		.wb_addr            (wb_addr),
		.wb_data            (wb_data),
		.mem_write          (mem_write),
		.mem_addr           (mem_addr),
		.mem_write_value    (mem_write_value)
	);

endmodule

`default_nettype wire

/* tb_exe_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module tb_exe_core;
	import cpu_pkg::*;

	localparam int CLK_PERIOD   = 10;
	localparam int RESET_CYCLES = 8;
	localparam int N_DIRECTED   = 40;  // Upper bound on directed instructions
	localparam int N_RANDOM     = 600;
	localparam logic [1:0] K_NONE = 2'd0;
	localparam logic [1:0] K_WB   = 2'd1;
	localparam logic [1:0] K_ST   = 2'd2;

	logic               clk = 1'b0;
	logic               rst_n;
	logic               hold;
	logic [`REG_W-1:0]  instr;
	logic               instr_valid;
	logic               instr_ready;
	logic               wb_valid;
	logic [`REG_AW-1:0] wb_addr;
	logic [`REG_W-1:0]  wb_data;
	logic               mem_write;
	logic [`REG_W-1:0]  mem_addr;
	logic [`REG_W-1:0]  mem_write_value;

	logic [`REG_CNT-1:0][`REG_W-1:0] model_regs;  // Architectural state of the model
	logic [1:0]        exp_kind [$];
	logic [`REG_W-1:0] exp_addr [$];
	logic [`REG_W-1:0] exp_data [$];
	int                exp_cycle [$];
	int                cycle_cnt = 0;
	bit                random_hold = 1'b0;
	logic [1:0]        got_kind;
	logic [`REG_W-1:0] got_addr, got_data;
	int                got_cycle;

	exe_core u_dut (
		.clk             (clk),
		.rst_n           (rst_n),
		.hold            (hold),
		.instr           (instr),
		.instr_valid     (instr_valid),
		.instr_ready     (instr_ready),
		.wb_valid        (wb_valid),
		.wb_addr         (wb_addr),
		.wb_data         (wb_data),
		.mem_write       (mem_write),
		.mem_addr        (mem_addr),
		.mem_write_value (mem_write_value)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("FAIL time=%0t signal=%s expected=%0h actual=%0h",
				$time, name, expected, actual);
			$display("TEST FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic logic [15:0] enc_i8(input logic [4:0] op, input logic [2:0] rx,
			input logic [7:0] imm);
		return {op, rx, imm};
	endfunction

	function automatic logic [15:0] enc_r(input logic [4:0] op, input logic [2:0] rx,
			input logic [2:0] ry, input logic [4:0] low);
		return {op, rx, ry, low};
	endfunction

	// Returns {kind, addr, data} and commits a register write to regs
	function automatic logic [33:0] model_exec(input logic [15:0] ins,
			inout logic [`REG_CNT-1:0][`REG_W-1:0] regs);
		logic [2:0]  rx, ry, dst;
		logic [15:0] a, b, res, addr;
		logic [3:0]  sa;
		logic [1:0]  kind;
		rx   = ins[10:8];
		ry   = ins[7:5];
		a    = regs[rx];
		b    = regs[ry];
		sa   = (ins[4:2] == 3'd0) ? 4'd8 : {1'b0, ins[4:2]};  // Zero means 8
		kind = K_WB;
		dst  = rx;
		res  = '0;
		addr = '0;
		case (ins[15:11])
			OPC_ADDIU:  res = a + {{8{ins[7]}}, ins[7:0]};
			OPC_ADDIU3: begin
				res = a + {{12{ins[3]}}, ins[3:0]};
				dst = ry;
			end
			OPC_LI:     res = {8'h00, ins[7:0]};
			OPC_RRR: begin
				dst = ins[4:2];
				case (ins[1:0])
					2'b01:   res = a + b;
					2'b11:   res = a - b;
					default: kind = K_NONE;
				endcase
			end
			OPC_LOGIC: case (ins[4:0])
				5'b01100: res = a & b;
				5'b01101: res = a | b;
				default:  kind = K_NONE;
			endcase
			OPC_SHIFT: case (ins[1:0])
				2'b00:   res = b << sa;
				2'b10:   res = b >> sa;
				2'b11:   res = 16'($signed(b) >>> sa);
				default: kind = K_NONE;
			endcase
			OPC_MOVE: if (ins[4:0] == 5'd0) res = b; else kind = K_NONE;
			OPC_SW: begin
				kind = K_ST;
				addr = a + {{11{ins[4]}}, ins[4:0]};
				res  = b;
			end
			default: kind = K_NONE;  // Everything else behaves as NOP
		endcase
		if (kind == K_WB) begin
			regs[dst] = res;
			addr      = {13'd0, dst};
		end
		return {kind, addr, res};
	endfunction

	function automatic logic [15:0] rand_instr();
		logic [2:0]  rx, ry, rz;
		logic [7:0]  imm;
		logic [15:0] word;
		rx  = 3'($urandom);
		ry  = 3'($urandom);
		rz  = 3'($urandom);
		imm = 8'($urandom);
		case ($urandom % 10)
			0: word = enc_i8(OPC_LI, rx, imm);
			1: word = enc_i8(OPC_ADDIU, rx, imm);
			2: word = enc_r(OPC_ADDIU3, rx, ry, imm[4:0]);
			3: word = enc_r(OPC_RRR, rx, ry, {rz, imm[0], 1'b1});  // ADDU or SUBU
			4: word = enc_r(OPC_LOGIC, rx, ry, {4'b0110, imm[0]});
			5: word = enc_r(OPC_SHIFT, rx, ry, {rz, imm[1], imm[1] & imm[0]});
			6: word = enc_r(OPC_MOVE, rx, ry, 5'd0);
			7: word = enc_r(OPC_SW, rx, ry, imm[4:0]);
			8: word = enc_r(OPC_NOP, 3'd0, 3'd0, 5'd0);
			default: word = 16'($urandom);
		endcase
		return word;
	endfunction

	// Holds the word until accepted, called on a falling edge
	task automatic send(input logic [15:0] ins);
		logic [33:0] exp_v;
		bit          accepted;
		accepted = 1'b0;
		while (!accepted) begin
			hold        = random_hold && ($urandom % 4 == 0);
			instr       = ins;
			instr_valid = 1'b1;
			accepted    = !hold;
			if (accepted) begin
				exp_v = model_exec(ins, model_regs);
				if (exp_v[33:32] != K_NONE) begin
					exp_kind.push_back(exp_v[33:32]);
					exp_addr.push_back(exp_v[31:16]);
					exp_data.push_back(exp_v[15:0]);
					exp_cycle.push_back(cycle_cnt + 2);  // Two cycles after it is presented
				end
			end
			@(negedge clk);
		end
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			hold        = random_hold && ($urandom % 2 == 0);
			instr_valid = 1'b0;
			instr       = 16'($urandom);  // Junk word must be ignored
			@(negedge clk);
		end
	endtask

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	initial begin
		void'($urandom(38));
		rst_n       = 1'b0;
		hold        = 1'b0;
		instr       = '0;
		instr_valid = 1'b0;
		model_regs  = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		idle(6);
		check_value("wb_valid", 32'(wb_valid), 32'd0);
		check_value("mem_write", 32'(mem_write), 32'd0);
		send(enc_r(OPC_MOVE, 3'd3, 3'd6, 5'd0));  // Registers start at zero
		send(enc_r(OPC_MOVE, 3'd0, 3'd7, 5'd0));
		send(enc_i8(OPC_LI, 3'd1, 8'hF0));
		send(enc_i8(OPC_LI, 3'd2, 8'h05));
		send(enc_i8(OPC_ADDIU, 3'd2, 8'h80));  // -128
		send(enc_i8(OPC_ADDIU, 3'd1, 8'h7F));
		send(enc_r(OPC_ADDIU3, 3'd1, 3'd3, 5'h0F));
		send(enc_r(OPC_ADDIU3, 3'd2, 3'd4, 5'h07));
		send(enc_i8(OPC_LI, 3'd5, 8'h81));
		send(enc_r(OPC_SHIFT, 3'd5, 3'd5, {3'd0, 2'b00}));  // SLL by 8 gives a negative value
		send(enc_r(OPC_SHIFT, 3'd6, 3'd5, {3'd3, 2'b11}));
		send(enc_r(OPC_SHIFT, 3'd7, 3'd5, {3'd0, 2'b10}));
		send(enc_r(OPC_SHIFT, 3'd6, 3'd5, {3'd0, 2'b11}));
		send(enc_r(OPC_SHIFT, 3'd0, 3'd1, {3'd5, 2'b00}));
		send(enc_r(OPC_RRR, 3'd1, 3'd2, {3'd3, 2'b01}));
		send(enc_r(OPC_RRR, 3'd2, 3'd1, {3'd4, 2'b11}));
		send(enc_r(OPC_LOGIC, 3'd1, 3'd5, 5'b01100));
		send(enc_r(OPC_LOGIC, 3'd2, 3'd6, 5'b01101));
		// Dependency chains
		send(enc_i8(OPC_LI, 3'd0, 8'h03));
		send(enc_i8(OPC_ADDIU, 3'd0, 8'h01));
		send(enc_r(OPC_RRR, 3'd0, 3'd0, {3'd1, 2'b01}));
		send(enc_r(OPC_NOP, 3'd0, 3'd0, 5'd0));
		send(enc_r(OPC_RRR, 3'd1, 3'd0, {3'd2, 2'b11}));  // R1 from two slots back
		send(enc_r(OPC_MOVE, 3'd3, 3'd2, 5'd0));
		send(enc_r(OPC_SHIFT, 3'd4, 3'd3, {3'd2, 2'b10}));
		send(enc_r(OPC_SW, 3'd1, 3'd2, 5'h1F));
		send(enc_r(OPC_SW, 3'd4, 3'd0, 5'h05));
		send(enc_r(OPC_MOVE, 3'd5, 3'd1, 5'd0));
		idle(4);
		random_hold = 1'b1;
		for (int i = 0; i < N_RANDOM; i++) begin
			if ($urandom % 8 == 0) idle(1);
			send(rand_instr());
		end
		random_hold = 1'b0;
		idle(5);
		if (exp_kind.size() != 0) begin
			$display("ERROR: %0d expected results never appeared", exp_kind.size());
			$display("TEST FAIL");
			$fatal(1, "missing results");
		end else begin
			$display("TEST PASS");
			$finish;
		end
	end

	////////////////////////////////////////
	// Comparison
	////////////////////////////////////////

	// Ready only while the stage is not held
	always @(posedge clk) begin
		check_value("instr_ready", 32'(instr_ready), 32'(!hold));
	end

	always @(negedge clk) begin
		if (rst_n && (wb_valid || mem_write)) begin
			if (exp_kind.size() == 0) begin
				$display("ERROR: output pulse at %0t with no instruction outstanding", $time);
				$display("TEST FAIL");
				$fatal(1, "unexpected output");
			end else begin
				got_kind  = exp_kind.pop_front();
				got_addr  = exp_addr.pop_front();
				got_data  = exp_data.pop_front();
				got_cycle = exp_cycle.pop_front();
				check_value("result cycle", cycle_cnt, got_cycle);
				check_value("wb_valid", 32'(wb_valid), 32'(got_kind == K_WB));
				check_value("mem_write", 32'(mem_write), 32'(got_kind == K_ST));
				if (got_kind == K_WB) begin
					check_value("wb_addr", 32'(wb_addr), 32'(got_addr));
					check_value("wb_data", 32'(wb_data), 32'(got_data));
				end else begin
					check_value("mem_addr", 32'(mem_addr), 32'(got_addr));
					check_value("mem_write_value", 32'(mem_write_value), 32'(got_data));
				end
			end
		end
	end

	initial begin
		#((RESET_CYCLES + (N_DIRECTED + N_RANDOM) * 4 + 200) * CLK_PERIOD);
		$display("ERROR: watchdog expired before the test finished");
		$display("TEST FAIL");
		$fatal(1, "timeout");
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+.
cpu_pkg.sv
reg_file.sv
id_exe.sv
exe_alu.sv
exe_core.sv
tb_exe_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the exe_core testbench with Verilator.
# The run passes only if the log holds the pass line.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary -j 0 --top-module tb_exe_core -f sources.f -o sim_exe_core \
	&& ./obj_dir/sim_exe_core > sim.log 2>&1

cat sim.log 2>/dev/null
grep -qx "TEST PASS" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
